//--- rtl/shell_pkg.sv
package shell_pkg;

    localparam int ADDR_WIDTH   = 32;  // AXI-Lite address
    localparam int DATA_WIDTH   = 32;  // AXI-Lite data
    localparam int STREAM_WIDTH = 64;  // Network tdata
    localparam int REGION_LSB   = 20;  // Region field is addr[21:20]

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2,
        DECERR = 2'd3
    } axi_resp_e;

    // Control address map, one region per 1 MB
    typedef enum logic [1:0] {
        APP      = 2'd0,
        NET_ISO  = 2'd1,  // No longer present
        CTRL_ISO = 2'd2,  // No longer present
        DECOUPLE = 2'd3
    } region_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } shell_op_e;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
    } lite_aw_t;  // Also used for AR

    typedef struct packed {
        logic [DATA_WIDTH-1:0]   data;
        logic [DATA_WIDTH/8-1:0] strb;
    } lite_w_t;

    typedef struct packed {
        axi_resp_e resp;
    } lite_b_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        axi_resp_e             resp;
    } lite_r_t;

    // Request from the control module to one target
    typedef struct packed {
        shell_op_e               op;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   wdata;
        logic [DATA_WIDTH/8-1:0] wstrb;
    } shell_req_t;

    typedef struct packed {
        axi_resp_e             resp;
        logic [DATA_WIDTH-1:0] rdata;  // Zero for writes
    } shell_rsp_t;

    typedef struct packed {
        logic [STREAM_WIDTH-1:0]   tdata;
        logic [STREAM_WIDTH/8-1:0] tkeep;
        logic                      tlast;
    } axis_beat_t;

endpackage

//--- rtl/shell_xbar_ctrl.sv
module shell_xbar_ctrl (
    input  logic                   aclk,
    input  logic                   rst,
    input  shell_pkg::lite_aw_t    ctrl_aw,
    input  logic                   ctrl_awvalid,
    output logic                   ctrl_awready,
    input  shell_pkg::lite_w_t     ctrl_w,
    input  logic                   ctrl_wvalid,
    output logic                   ctrl_wready,
    output shell_pkg::lite_b_t     ctrl_b,
    output logic                   ctrl_bvalid,
    input  logic                   ctrl_bready,
    input  shell_pkg::lite_aw_t    ctrl_ar,
    input  logic                   ctrl_arvalid,
    output logic                   ctrl_arready,
    output shell_pkg::lite_r_t     ctrl_r,
    output logic                   ctrl_rvalid,
    input  logic                   ctrl_rready,
    output shell_pkg::shell_req_t  req,
    output logic                   app_req_valid,
    output logic                   reg_req_valid,
    input  shell_pkg::shell_rsp_t  app_rsp,
    input  logic                   app_rsp_valid,
    input  shell_pkg::shell_rsp_t  reg_rsp,
    input  logic                   reg_rsp_valid
);

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,     // Request pulse or local DECERR
        WAIT_RSP,
        RESP_B,
        RESP_R
    } state_e;

    state_e                state;
    state_e                resp_state;  // B or R depending on op
    shell_pkg::shell_req_t req_q;
    shell_pkg::shell_rsp_t rsp_q;
    shell_pkg::shell_rsp_t rsp_sel;
    shell_pkg::region_e    region;
    logic                  wr_accept;
    logic                  rd_accept;
    logic                  target_hit;
    logic                  rsp_hit;

    // Writes win when both AW and W are present
    assign wr_accept = (state == IDLE) && ctrl_awvalid && ctrl_wvalid;
    assign rd_accept = (state == IDLE) && ctrl_arvalid && !(ctrl_awvalid && ctrl_wvalid);

    assign ctrl_awready = wr_accept;
    assign ctrl_wready  = wr_accept;  // AW and W taken together
    assign ctrl_arready = rd_accept;

    assign region     = shell_pkg::region_e'(req_q.addr[shell_pkg::REGION_LSB +: 2]);
    assign resp_state = (req_q.op == shell_pkg::OP_WRITE) ? RESP_B : RESP_R;

    assign req           = req_q;  // Shared by both targets
    assign app_req_valid = (state == ISSUE) && (region == shell_pkg::APP);
    assign reg_req_valid = (state == ISSUE) && (region == shell_pkg::DECOUPLE);
    assign target_hit    = app_req_valid || reg_req_valid;

    // Only the addressed target may answer
    assign rsp_hit = (region == shell_pkg::APP) ? app_rsp_valid : reg_rsp_valid;
    assign rsp_sel = (region == shell_pkg::APP) ? app_rsp : reg_rsp;

    assign ctrl_bvalid = (state == RESP_B);
    assign ctrl_rvalid = (state == RESP_R);
    assign ctrl_b      = '{resp: rsp_q.resp};
    assign ctrl_r      = '{data: rsp_q.rdata, resp: rsp_q.resp};

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_accept || rd_accept) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: state <= target_hit ? WAIT_RSP : resp_state;  // Dropped regions skip wait
                WAIT_RSP: begin
                    if (rsp_hit) begin
                        state <= resp_state;
                    end
                end
                RESP_B: begin
                    if (ctrl_bready) begin
                        state <= IDLE;
                    end
                end
                RESP_R: begin
                    if (ctrl_rready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Captured transaction and its response
    always_ff @(posedge aclk) begin
        if (wr_accept) begin
            req_q.op    <= shell_pkg::OP_WRITE;
            req_q.addr  <= ctrl_aw.addr;
            req_q.wdata <= ctrl_w.data;
            req_q.wstrb <= ctrl_w.strb;
        end else if (rd_accept) begin
            req_q.op    <= shell_pkg::OP_READ;
            req_q.addr  <= ctrl_ar.addr;
            req_q.wdata <= '0;
            req_q.wstrb <= '0;  // Nothing to write
        end
        if ((state == ISSUE) && !target_hit) begin
            rsp_q <= '{resp: shell_pkg::DECERR, rdata: '0};
        end else if ((state == WAIT_RSP) && rsp_hit) begin
            rsp_q <= rsp_sel;
        end
    end

    a_one_target: assert property (@(posedge aclk) disable iff (rst)
        !(app_req_valid && reg_req_valid));

    // AXI hold rule on both response channels
    a_b_hold: assert property (@(posedge aclk) disable iff (rst)
        ctrl_bvalid && !ctrl_bready |=> ctrl_bvalid && $stable(ctrl_b));
    a_r_hold: assert property (@(posedge aclk) disable iff (rst)
        ctrl_rvalid && !ctrl_rready |=> ctrl_rvalid && $stable(ctrl_r));

endmodule

//--- rtl/decouple_regs.sv
module decouple_regs (
    input  logic                   aclk,
    input  logic                   rst,
    input  shell_pkg::shell_req_t  req,
    input  logic                   req_valid,
    output shell_pkg::shell_rsp_t  rsp,
    output logic                   rsp_valid,
    output logic                   decouple,
    output logic                   pr_rst
);

    logic assert_reset;
    logic wr_hit;

    // Address is not decoded so the word repeats over the region
    assign wr_hit = req_valid && (req.op == shell_pkg::OP_WRITE) && req.wstrb[0];

    always_ff @(posedge aclk) begin
        if (rst) begin
            decouple     <= 1'b0;
            assert_reset <= 1'b0;
        end else if (wr_hit) begin
            decouple     <= req.wdata[0];  // Bit 0
            assert_reset <= req.wdata[1];  // Bit 1
        end
    end

    // Fixed one-cycle answer
    always_ff @(posedge aclk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

    // Read data is the current value, upper bits zero
    always_ff @(posedge aclk) begin
        if (req_valid) begin
            rsp.resp  <= shell_pkg::OKAY;
            rsp.rdata <= {{(shell_pkg::DATA_WIDTH - 2){1'b0}}, assert_reset, decouple};
        end
    end

    // Application held in reset by shell reset or by software
    always_ff @(posedge aclk) begin
        pr_rst <= rst || assert_reset;
    end

endmodule

//--- rtl/app_ctrl_guard.sv
module app_ctrl_guard #(
    parameter int TIMEOUT_CYCLES = 31
) (
    input  logic                   aclk,
    input  logic                   rst,
    input  shell_pkg::shell_req_t  req,
    input  logic                   req_valid,
    input  logic                   decouple,
    output shell_pkg::shell_rsp_t  rsp,
    output logic                   rsp_valid,
    output shell_pkg::lite_aw_t    app_aw,
    output logic                   app_awvalid,
    input  logic                   app_awready,
    output shell_pkg::lite_w_t     app_w,
    output logic                   app_wvalid,
    input  logic                   app_wready,
    input  shell_pkg::lite_b_t     app_b,
    input  logic                   app_bvalid,
    output logic                   app_bready,
    output shell_pkg::lite_aw_t    app_ar,
    output logic                   app_arvalid,
    input  logic                   app_arready,
    input  shell_pkg::lite_r_t     app_r,
    input  logic                   app_rvalid,
    output logic                   app_rready
);

    localparam int TIMER_WIDTH = $clog2(TIMEOUT_CYCLES + 1);

    logic                   busy;  // Access out to the application
    shell_pkg::shell_op_e   op_q;
    logic [TIMER_WIDTH-1:0] timer;
    logic                   app_done;
    logic                   timed_out;

    // Always accept responses, late ones simply fall on the floor
    assign app_bready = 1'b1;
    assign app_rready = 1'b1;

    assign app_done  = busy && ((op_q == shell_pkg::OP_WRITE) ? app_bvalid : app_rvalid);
    assign timed_out = busy && !app_done && (timer == TIMER_WIDTH'(TIMEOUT_CYCLES - 1));

    always_ff @(posedge aclk) begin
        if (rst) begin
            busy        <= 1'b0;
            timer       <= '0;
            rsp_valid   <= 1'b0;
            app_awvalid <= 1'b0;
            app_wvalid  <= 1'b0;
            app_arvalid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            if (req_valid) begin
                if (decouple) begin
                    rsp_valid <= 1'b1;  // Blocked, app port untouched
                end else begin
                    busy        <= 1'b1;
                    timer       <= '0;
                    app_awvalid <= (req.op == shell_pkg::OP_WRITE);
                    app_wvalid  <= (req.op == shell_pkg::OP_WRITE);
                    app_arvalid <= (req.op == shell_pkg::OP_READ);
                end
            end else if (busy) begin
                timer <= timer + 1'b1;
                if (app_awready) begin
                    app_awvalid <= 1'b0;
                end
                if (app_wready) begin
                    app_wvalid <= 1'b0;
                end
                if (app_arready) begin
                    app_arvalid <= 1'b0;
                end
                if (app_done || timed_out) begin
                    busy        <= 1'b0;
                    rsp_valid   <= 1'b1;
                    app_awvalid <= 1'b0;  // Abandon anything still pending
                    app_wvalid  <= 1'b0;
                    app_arvalid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid) begin
            op_q        <= req.op;
            app_aw.addr <= req.addr;
            app_ar.addr <= req.addr;
            app_w.data  <= req.wdata;
            app_w.strb  <= req.wstrb;
        end
        if ((req_valid && decouple) || timed_out) begin
            rsp <= '{resp: shell_pkg::SLVERR, rdata: '0};
        end else if (app_done) begin
            if (op_q == shell_pkg::OP_WRITE) begin
                rsp <= '{resp: app_b.resp, rdata: '0};
            end else begin
                rsp <= '{resp: app_r.resp, rdata: app_r.data};
            end
        end
    end

    // Control module keeps a single access in flight
    a_no_overlap: assert property (@(posedge aclk) disable iff (rst)
        req_valid |-> !busy);

endmodule

//--- rtl/net_stream_gate.sv
module net_stream_gate (
    input  logic                   aclk,
    input  logic                   rst,
    input  logic                   decouple,
    input  shell_pkg::axis_beat_t  tx_s,
    input  logic                   tx_s_valid,
    output logic                   tx_s_ready,
    output shell_pkg::axis_beat_t  tx_m,
    output logic                   tx_m_valid,
    input  logic                   tx_m_ready,
    input  shell_pkg::axis_beat_t  rx_s,
    input  logic                   rx_s_valid,
    output logic                   rx_s_ready,
    output shell_pkg::axis_beat_t  rx_m,
    output logic                   rx_m_valid,
    input  logic                   rx_m_ready
);

    // Bit 0 is tx, bit 1 is rx
    logic [1:0] in_packet;
    logic [1:0] closed;
    logic [1:0] beat_done;
    logic [1:0] beat_last;

    // Close only between packets
    assign closed = {2{decouple}} & ~in_packet;

    assign tx_m       = tx_s;
    assign tx_m_valid = tx_s_valid && !closed[0];
    assign tx_s_ready = tx_m_ready && !closed[0];  // Stall the application

    assign rx_m       = rx_s;
    assign rx_m_valid = rx_s_valid && !closed[1];
    assign rx_s_ready = rx_m_ready || closed[1];   // Drain and drop

    // Only beats that actually pass count toward packet state
    assign beat_done = {rx_m_valid && rx_m_ready, tx_m_valid && tx_m_ready};
    assign beat_last = {rx_s.tlast, tx_s.tlast};

    always_ff @(posedge aclk) begin
        if (rst) begin
            in_packet <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (beat_done[i]) begin
                    in_packet[i] <= !beat_last[i];
                end
            end
        end
    end

    a_tx_source: assert property (@(posedge aclk) disable iff (rst)
        tx_m_valid |-> tx_s_valid);

endmodule

//--- rtl/interface_shell.sv
module interface_shell #(
    parameter int TIMEOUT_CYCLES = 31  // App response timeout
) (
    input  logic                   aclk,
    input  logic                   rst,
    input  shell_pkg::lite_aw_t    ctrl_aw,
    input  logic                   ctrl_awvalid,
    output logic                   ctrl_awready,
    input  shell_pkg::lite_w_t     ctrl_w,
    input  logic                   ctrl_wvalid,
    output logic                   ctrl_wready,
    output shell_pkg::lite_b_t     ctrl_b,
    output logic                   ctrl_bvalid,
    input  logic                   ctrl_bready,
    input  shell_pkg::lite_aw_t    ctrl_ar,
    input  logic                   ctrl_arvalid,
    output logic                   ctrl_arready,
    output shell_pkg::lite_r_t     ctrl_r,
    output logic                   ctrl_rvalid,
    input  logic                   ctrl_rready,
    output shell_pkg::lite_aw_t    app_aw,
    output logic                   app_awvalid,
    input  logic                   app_awready,
    output shell_pkg::lite_w_t     app_w,
    output logic                   app_wvalid,
    input  logic                   app_wready,
    input  shell_pkg::lite_b_t     app_b,
    input  logic                   app_bvalid,
    output logic                   app_bready,
    output shell_pkg::lite_aw_t    app_ar,
    output logic                   app_arvalid,
    input  logic                   app_arready,
    input  shell_pkg::lite_r_t     app_r,
    input  logic                   app_rvalid,
    output logic                   app_rready,
    input  shell_pkg::axis_beat_t  tx_s,
    input  logic                   tx_s_valid,
    output logic                   tx_s_ready,
    output shell_pkg::axis_beat_t  tx_m,
    output logic                   tx_m_valid,
    input  logic                   tx_m_ready,
    input  shell_pkg::axis_beat_t  rx_s,
    input  logic                   rx_s_valid,
    output logic                   rx_s_ready,
    output shell_pkg::axis_beat_t  rx_m,
    output logic                   rx_m_valid,
    input  logic                   rx_m_ready,
    output logic                   pr_rst
);

    shell_pkg::shell_req_t req;  // Shared request bus
    logic                  app_req_valid;
    logic                  reg_req_valid;
    shell_pkg::shell_rsp_t app_rsp;
    logic                  app_rsp_valid;
    shell_pkg::shell_rsp_t reg_rsp;
    logic                  reg_rsp_valid;
    logic                  decouple;

    shell_xbar_ctrl u_xbar (.*);

    decouple_regs u_regs (
        .*,
        .req_valid (reg_req_valid),
        .rsp       (reg_rsp),
        .rsp_valid (reg_rsp_valid)
    );

    app_ctrl_guard #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_guard (
        .*,
        .req_valid (app_req_valid),
        .rsp       (app_rsp),
        .rsp_valid (app_rsp_valid)
    );

    net_stream_gate u_gate (.*);  // Network paths

endmodule

//--- verif/tb_interface_shell.sv
module tb_interface_shell;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20;  // Short app timeout for the silent cases
    localparam int WAIT_LIMIT     = 20;  // Cycles allowed for any handshake
    localparam int RESP_LIMIT     = TIMEOUT_CYCLES + 12;

    logic                  aclk;
    logic                  rst;
    shell_pkg::lite_aw_t   ctrl_aw;
    logic                  ctrl_awvalid;
    logic                  ctrl_awready;
    shell_pkg::lite_w_t    ctrl_w;
    logic                  ctrl_wvalid;
    logic                  ctrl_wready;
    shell_pkg::lite_b_t    ctrl_b;
    logic                  ctrl_bvalid;
    logic                  ctrl_bready;
    shell_pkg::lite_aw_t   ctrl_ar;
    logic                  ctrl_arvalid;
    logic                  ctrl_arready;
    shell_pkg::lite_r_t    ctrl_r;
    logic                  ctrl_rvalid;
    logic                  ctrl_rready;
    shell_pkg::lite_aw_t   app_aw;
    logic                  app_awvalid;
    logic                  app_awready;
    shell_pkg::lite_w_t    app_w;
    logic                  app_wvalid;
    logic                  app_wready;
    shell_pkg::lite_b_t    app_b;
    logic                  app_bvalid;
    logic                  app_bready;
    shell_pkg::lite_aw_t   app_ar;
    logic                  app_arvalid;
    logic                  app_arready;
    shell_pkg::lite_r_t    app_r;
    logic                  app_rvalid;
    logic                  app_rready;
    shell_pkg::axis_beat_t tx_s;
    logic                  tx_s_valid;
    logic                  tx_s_ready;
    shell_pkg::axis_beat_t tx_m;
    logic                  tx_m_valid;
    logic                  tx_m_ready;
    shell_pkg::axis_beat_t rx_s;
    logic                  rx_s_valid;
    logic                  rx_s_ready;
    shell_pkg::axis_beat_t rx_m;
    logic                  rx_m_valid;
    logic                  rx_m_ready;
    logic                  pr_rst;

    int                    errors    = 0;
    int                    checks    = 0;
    logic [15:0]           lfsr      = 16'd85;
    logic                  app_quiet = 1'b0;  // No app valid may rise while set
    logic                  gate_closed = 1'b0;
    logic                  silent    = 1'b0;  // Responder never answers
    int                    app_delay = 0;
    int                    app_seen  = 0;     // Completed app accesses
    shell_pkg::axi_resp_e  app_bresp = shell_pkg::OKAY;
    shell_pkg::axi_resp_e  app_rresp = shell_pkg::OKAY;
    logic [31:0]           app_rdata = '0;
    logic [7:0]            ready_pat = 8'hff;
    logic [31:0]           exp_addr  = '0;    // What the app port must see
    logic [31:0]           exp_data  = '0;
    logic [3:0]            exp_strb  = '0;

    interface_shell #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) interface_shell_i (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;  // 100 MHz
    end

    task automatic check_value(input string name, input logic [95:0] expected,
                               input logic [95:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_range(input string name, input int lo, input int hi, input int actual);
        checks++;
        assert (actual >= lo && actual <= hi) else begin
            errors++;
            $display("[ERROR] %s expected %0d..%0d actual %0d", name, lo, hi, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout while waiting for %s", what);
    endtask

    // Galois form with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    function automatic logic [31:0] draw(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};  // One step per bit
        end
        return v;
    endfunction

    function automatic logic [31:0] region_addr(input logic [1:0] region);
        return {10'd0, region, 20'(draw(20))};  // Random offset inside the region
    endfunction

    function automatic shell_pkg::axis_beat_t make_beat(input logic last);
        return '{tdata: {draw(32), draw(32)}, tkeep: 8'(draw(8)), tlast: last};
    endfunction

    // Next app reply is chosen before the access starts
    task automatic set_app_reply(input logic quiet);
        silent    = quiet;
        app_delay = draw(2);
        app_bresp = draw(1) ? shell_pkg::SLVERR : shell_pkg::OKAY;
        app_rresp = draw(1) ? shell_pkg::SLVERR : shell_pkg::OKAY;
        app_rdata = draw(32);
        ready_pat = 8'(draw(8)) | 8'h11;  // Ready at least every fourth cycle
    endtask

    // One AXI-Lite access where lat counts cycles from acceptance to B or R valid
    task automatic ctrl_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] strb, output logic [1:0] resp,
                               output logic [31:0] rdata, output int lat);
        int n;
        @(negedge aclk);
        ctrl_aw      = '{addr: addr};
        ctrl_ar      = '{addr: addr};
        ctrl_w       = '{data: wdata, strb: strb};
        ctrl_awvalid = wr;
        ctrl_wvalid  = wr;
        ctrl_arvalid = !wr;
        n = 0;
        #1;
        while (!(ctrl_awready || ctrl_arready) && n < WAIT_LIMIT) begin
            @(negedge aclk);
            #1;
            n++;
        end
        if (!(ctrl_awready || ctrl_arready)) begin
            report_timeout("control address handshake");
        end else begin
            // AW and W together on a write, AR alone on a read
            check_value("ctrl_ready", {wr, wr, !wr},
                        {ctrl_awready, ctrl_wready, ctrl_arready});
        end
        @(negedge aclk);
        {ctrl_awvalid, ctrl_wvalid, ctrl_arvalid} = '0;
        lat = 1;
        while (!(ctrl_bvalid || ctrl_rvalid) && lat < RESP_LIMIT) begin
            @(negedge aclk);
            lat++;
        end
        if (!(ctrl_bvalid || ctrl_rvalid)) begin
            report_timeout("control response");
        end else begin
            check_value("resp_channel", {wr, !wr}, {ctrl_bvalid, ctrl_rvalid});
        end
        resp  = wr ? ctrl_b.resp : ctrl_r.resp;
        rdata = ctrl_r.data;
        repeat (draw(2)) @(negedge aclk);  // Random B/R back-pressure
        ctrl_bready = 1'b1;
        ctrl_rready = 1'b1;
        @(negedge aclk);
        ctrl_bready = 1'b0;
        ctrl_rready = 1'b0;
    endtask

    // Same beat on tx and rx and both must come out unchanged
    task automatic send_beat(input shell_pkg::axis_beat_t beat);
        int n;
        @(negedge aclk);
        tx_s       = beat;
        rx_s       = beat;
        tx_s_valid = 1'b1;
        rx_s_valid = 1'b1;
        n = 0;
        #1;
        while (!tx_s_ready && n < WAIT_LIMIT) begin
            @(negedge aclk);
            #1;
            n++;
        end
        if (!tx_s_ready) begin
            report_timeout("tx_s_ready");
        end else begin
            check_value("tx_beat", {1'b1, beat}, {tx_m_valid, tx_m});
            check_value("rx_beat", {1'b1, beat}, {rx_m_valid, rx_m});
        end
        @(negedge aclk);
        tx_s_valid = 1'b0;
        rx_s_valid = 1'b0;
    endtask

    // Application slave that answers after app_delay cycles unless silent
    initial begin : app_responder
        int   tick;
        int   wait_cnt;
        logic got_aw;
        logic got_w;
        logic got_ar;
        tick     = 0;
        wait_cnt = 0;
        {got_aw, got_w, got_ar} = '0;
        {app_awready, app_wready, app_arready} = '0;
        app_b      = '{resp: shell_pkg::OKAY};
        app_r      = '{data: '0, resp: shell_pkg::OKAY};
        app_bvalid = 1'b0;
        app_rvalid = 1'b0;
        forever begin
            @(negedge aclk);
            app_bvalid = 1'b0;
            app_rvalid = 1'b0;
            if ((got_aw && got_w) || got_ar) begin
                if (silent) begin
                    {got_aw, got_w, got_ar} = '0;  // Drop it so the guard times out
                end else if (wait_cnt < app_delay) begin
                    wait_cnt++;
                end else begin
                    app_b      = '{resp: app_bresp};
                    app_r      = '{data: app_rdata, resp: app_rresp};
                    app_bvalid = got_aw;
                    app_rvalid = got_ar;
                    {got_aw, got_w, got_ar} = '0;
                    wait_cnt = 0;
                    app_seen++;
                end
            end
            tick++;
            app_awready = ready_pat[tick % 8];
            app_wready  = ready_pat[(tick + 3) % 8];
            app_arready = ready_pat[(tick + 5) % 8];
            if (app_awvalid && app_awready) begin
                got_aw = 1'b1;
                check_value("app_aw_addr", exp_addr, app_aw.addr);
            end
            if (app_wvalid && app_wready) begin
                got_w = 1'b1;
                check_value("app_w_data_strb", {exp_data, exp_strb}, {app_w.data, app_w.strb});
            end
            if (app_arvalid && app_arready) begin
                got_ar = 1'b1;
                check_value("app_ar_addr", exp_addr, app_ar.addr);
            end
        end
    end

    a_app_quiet: assert property (@(posedge aclk) disable iff (rst)
        app_quiet |-> !(app_awvalid || app_wvalid || app_arvalid))
        else check_value("app_valid_quiet", 3'b000,
                         $sampled({app_awvalid, app_wvalid, app_arvalid}));

    a_gate_closed: assert property (@(posedge aclk) disable iff (rst)
        gate_closed |-> ({tx_s_ready, tx_m_valid, rx_s_ready, rx_m_valid} == 4'b0010))
        else check_value("net_gate_closed", 4'b0010,
                         $sampled({tx_s_ready, tx_m_valid, rx_s_ready, rx_m_valid}));

    a_app_ready_high: assert property (@(posedge aclk) disable iff (rst)
        app_bready && app_rready)
        else check_value("app_bready_rready", 2'b11, $sampled({app_bready, app_rready}));

    initial begin : stimulus
        logic [1:0]  resp;
        logic [31:0] rdata;
        logic [31:0] wdata;
        int          lat;
        int          seen;
        rst          = 1'b1;
        ctrl_aw      = '0;
        ctrl_w       = '0;
        ctrl_ar      = '0;
        {ctrl_awvalid, ctrl_wvalid, ctrl_arvalid, ctrl_bready, ctrl_rready} = '0;
        tx_s         = '0;
        rx_s         = '0;
        {tx_s_valid, rx_s_valid} = '0;
        tx_m_ready   = 1'b1;
        rx_m_ready   = 1'b1;
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        check_value("pr_rst_in_reset", 1'b1, pr_rst);
        rst = 1'b0;
        @(negedge aclk);
        check_value("reset_outputs", '0, {ctrl_awready, ctrl_wready, ctrl_arready,
                    ctrl_bvalid, ctrl_rvalid, app_awvalid, app_wvalid, app_arvalid,
                    tx_m_valid, rx_m_valid, pr_rst});

        // Region 3 register written then read back from another offset
        for (int i = 0; i < 4; i++) begin
            wdata = draw(32);
            ctrl_access(1'b1, region_addr(2'd3), wdata, 4'h1, resp, rdata, lat);
            check_value("reg_write_resp", shell_pkg::OKAY, resp);
            check_value("reg_write_latency", 3, lat);
            check_value("pr_rst_follows_bit", wdata[1], pr_rst);
            ctrl_access(1'b0, region_addr(2'd3), '0, '0, resp, rdata, lat);
            check_value("reg_read_data", {30'd0, wdata[1:0]}, rdata);
            check_value("reg_read_resp", shell_pkg::OKAY, resp);
        end
        ctrl_access(1'b1, region_addr(2'd3), 32'h0, 4'h1, resp, rdata, lat);

        // Dropped regions answer locally
        app_quiet = 1'b1;
        for (int r = 1; r < 3; r++) begin
            ctrl_access(1'b1, region_addr(2'(r)), draw(32), 4'hf, resp, rdata, lat);
            check_value("decerr_write", shell_pkg::DECERR, resp);
            ctrl_access(1'b0, region_addr(2'(r)), '0, '0, resp, rdata, lat);
            check_value("decerr_read", shell_pkg::DECERR, resp);
        end
        app_quiet = 1'b0;

        // Region 0 through to the application port
        for (int i = 0; i < 6; i++) begin
            set_app_reply(1'b0);
            exp_addr = region_addr(2'd0);
            exp_data = draw(32);
            exp_strb = 4'(draw(4));
            seen     = app_seen;
            ctrl_access(1'b1, exp_addr, exp_data, exp_strb, resp, rdata, lat);
            check_value("app_write_resp", app_bresp, resp);
            check_value("app_write_count", seen + 1, app_seen);
            set_app_reply(1'b0);
            exp_addr = region_addr(2'd0);
            ctrl_access(1'b0, exp_addr, '0, '0, resp, rdata, lat);
            check_value("app_read_resp", app_rresp, resp);
            check_value("app_read_data", app_rdata, rdata);
        end

        // Guard times out on a silent application
        set_app_reply(1'b1);
        exp_addr = region_addr(2'd0);
        exp_data = draw(32);
        exp_strb = 4'hf;
        ctrl_access(1'b1, exp_addr, exp_data, exp_strb, resp, rdata, lat);
        check_value("timeout_write_resp", shell_pkg::SLVERR, resp);
        check_range("timeout_write_latency", TIMEOUT_CYCLES, TIMEOUT_CYCLES + 6, lat);
        exp_addr = region_addr(2'd0);
        ctrl_access(1'b0, exp_addr, '0, '0, resp, rdata, lat);
        check_value("timeout_read_resp", shell_pkg::SLVERR, resp);
        check_range("timeout_read_latency", TIMEOUT_CYCLES, TIMEOUT_CYCLES + 6, lat);
        silent = 1'b0;

        // Control accesses blocked while decoupled
        ctrl_access(1'b1, region_addr(2'd3), 32'h1, 4'h1, resp, rdata, lat);
        app_quiet = 1'b1;
        ctrl_access(1'b1, region_addr(2'd0), draw(32), 4'hf, resp, rdata, lat);
        check_value("decoupled_write_resp", shell_pkg::SLVERR, resp);
        ctrl_access(1'b0, region_addr(2'd0), '0, '0, resp, rdata, lat);
        check_value("decoupled_read_resp", shell_pkg::SLVERR, resp);
        app_quiet = 1'b0;
        ctrl_access(1'b1, region_addr(2'd3), 32'h2, 4'h1, resp, rdata, lat);
        check_value("pr_rst_set", 1'b1, pr_rst);
        ctrl_access(1'b1, region_addr(2'd3), 32'h0, 4'h1, resp, rdata, lat);
        check_value("pr_rst_clear", 1'b0, pr_rst);

        // Decouple lands in the middle of a packet
        send_beat(make_beat(1'b0));
        ctrl_access(1'b1, region_addr(2'd3), 32'h1, 4'h1, resp, rdata, lat);
        send_beat(make_beat(1'b0));
        send_beat(make_beat(1'b1));  // Packet completes
        @(negedge aclk);
        tx_s        = make_beat(1'b0);
        rx_s        = tx_s;
        tx_s_valid  = 1'b1;
        rx_s_valid  = 1'b1;
        gate_closed = 1'b1;
        repeat (8) @(negedge aclk);
        gate_closed = 1'b0;
        tx_s_valid  = 1'b0;
        rx_s_valid  = 1'b0;
        ctrl_access(1'b1, region_addr(2'd3), 32'h0, 4'h1, resp, rdata, lat);
        for (int i = 0; i < 3; i++) begin
            send_beat(make_beat(i == 2));
        end

        repeat (2) @(negedge aclk);
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- sources.f
rtl/shell_pkg.sv
rtl/shell_xbar_ctrl.sv
rtl/decouple_regs.sv
rtl/app_ctrl_guard.sv
rtl/net_stream_gate.sv
rtl/interface_shell.sv
verif/tb_interface_shell.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f sources.f --top-module tb_interface_shell -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "Build or simulation did not complete, see build.log and sim.log"
grep -q "^No errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
